/* verilog/periph_pkg.sv */
// shared sizes and codes; offsets are byte offsets inside a 64-byte region, upper address bits unused
package periph_pkg;

    localparam int unsigned ADDR_W   = 12;
    localparam int unsigned DATA_W   = 32;
    localparam int unsigned OFFS_W   = 6;   // addr[5:0] inside a region
    localparam int unsigned CNT_W    = 16;  // timer and pwm register width
    localparam int unsigned PWM_CH   = 3;
    localparam int unsigned GPIO_NUM = 16;

    // addr[7:6]
    localparam logic [1:0] REGION_TIMER = 2'd0;
    localparam logic [1:0] REGION_PWM   = 2'd1;
    localparam logic [1:0] REGION_GPIO  = 2'd2;
    localparam logic [1:0] REGION_NONE  = 2'd3;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // bus fsm states
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_WRESP = 2'd1;
    localparam logic [1:0] ST_RRESP = 2'd2;

    // timer map
    localparam logic [OFFS_W-1:0] TMR_CTRL     = 6'h00;  // bit0 enable, bit1 irq enable
    localparam logic [OFFS_W-1:0] TMR_PRESCALE = 6'h04;
    localparam logic [OFFS_W-1:0] TMR_COMPARE  = 6'h08;
    localparam logic [OFFS_W-1:0] TMR_COUNT    = 6'h0C;  // read only
    localparam logic [OFFS_W-1:0] TMR_STATUS   = 6'h10;  // bit0 pending, w1c

    // pwm map
    localparam logic [OFFS_W-1:0] PWM_PERIOD = 6'h00;
    localparam logic [OFFS_W-1:0] PWM_DUTY0  = 6'h04;
    localparam logic [OFFS_W-1:0] PWM_DUTY1  = 6'h08;
    localparam logic [OFFS_W-1:0] PWM_DUTY2  = 6'h0C;
    localparam logic [OFFS_W-1:0] PWM_ENABLE = 6'h10;

    // gpio map
    localparam logic [OFFS_W-1:0] GPIO_DIR = 6'h00;
    localparam logic [OFFS_W-1:0] GPIO_OUT = 6'h04;
    localparam logic [OFFS_W-1:0] GPIO_IN  = 6'h08;  // read only

endpackage

/* verilog/axil_slave_fsm.sv */
// one AXI4-Lite transaction at a time; only full-word writes land, partial strobes and region 3 get SLVERR
`timescale 1ns/1ps

module axil_slave_fsm (
    input  logic                            clk_i,
    input  logic                            rst_n_i,

    input  logic [periph_pkg::ADDR_W-1:0]   awaddr_i,
    input  logic                            awvalid_i,
    output logic                            awready_o,
    input  logic [periph_pkg::DATA_W-1:0]   wdata_i,
    input  logic [periph_pkg::DATA_W/8-1:0] wstrb_i,
    input  logic                            wvalid_i,
    output logic                            wready_o,
    output logic [1:0]                      bresp_o,
    output logic                            bvalid_o,
    input  logic                            bready_i,
    input  logic [periph_pkg::ADDR_W-1:0]   araddr_i,
    input  logic                            arvalid_i,
    output logic                            arready_o,
    output logic [periph_pkg::DATA_W-1:0]   rdata_o,
    output logic [1:0]                      rresp_o,
    output logic                            rvalid_o,
    input  logic                            rready_i,

    output logic [periph_pkg::OFFS_W-1:0]   reg_addr_o,
    output logic [periph_pkg::DATA_W-1:0]   reg_wdata_o,
    output logic                            timer_we_o,
    output logic                            pwm_we_o,
    output logic                            gpio_we_o,
    input  logic [periph_pkg::DATA_W-1:0]   timer_rdata_i,
    input  logic [periph_pkg::DATA_W-1:0]   pwm_rdata_i,
    input  logic [periph_pkg::DATA_W-1:0]   gpio_rdata_i
);
    import periph_pkg::*;

    logic [1:0]        state_q;
    logic              wr_pend;   // address and data both presented
    logic              wr_go;
    logic              rd_go;
    logic [1:0]        wr_region;
    logic [1:0]        rd_region;
    logic              wr_ok;
    logic [DATA_W-1:0] rd_mux;
    logic [DATA_W-1:0] rdata_q;
    logic [1:0]        rresp_q;
    logic [1:0]        bresp_q;

    assign wr_pend = awvalid_i && wvalid_i;
    assign wr_go   = (state_q == ST_IDLE) && wr_pend;
    assign rd_go   = (state_q == ST_IDLE) && !wr_pend && arvalid_i;  // write wins

    assign awready_o = wr_go;
    assign wready_o  = wr_go;
    assign arready_o = rd_go;

    assign wr_region = awaddr_i[OFFS_W+1:OFFS_W];
    assign rd_region = araddr_i[OFFS_W+1:OFFS_W];
    assign wr_ok     = (wr_region != REGION_NONE) && (&wstrb_i);

    // one offset bus shared by both directions
    assign reg_addr_o  = wr_pend ? awaddr_i[OFFS_W-1:0] : araddr_i[OFFS_W-1:0];
    assign reg_wdata_o = wdata_i;

    assign timer_we_o = wr_go && wr_ok && (wr_region == REGION_TIMER);
    assign pwm_we_o   = wr_go && wr_ok && (wr_region == REGION_PWM);
    assign gpio_we_o  = wr_go && wr_ok && (wr_region == REGION_GPIO);

    always_comb begin
        case (rd_region)
            REGION_TIMER: rd_mux = timer_rdata_i;
            REGION_PWM:   rd_mux = pwm_rdata_i;
            REGION_GPIO:  rd_mux = gpio_rdata_i;
            default:      rd_mux = '0;  // unmapped reads as zero
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            bresp_q <= RESP_OKAY;
            rresp_q <= RESP_OKAY;
            rdata_q <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (wr_go) begin
                        state_q <= ST_WRESP;
                        bresp_q <= wr_ok ? RESP_OKAY : RESP_SLVERR;
                    end else if (rd_go) begin
                        state_q <= ST_RRESP;
                        rdata_q <= rd_mux;  // sampled in the acceptance cycle
                        rresp_q <= (rd_region == REGION_NONE) ? RESP_SLVERR : RESP_OKAY;
                    end
                end
                ST_WRESP: if (bready_i) state_q <= ST_IDLE;
                ST_RRESP: if (rready_i) state_q <= ST_IDLE;
                default:  state_q <= ST_IDLE;
            endcase
        end
    end

    assign bvalid_o = (state_q == ST_WRESP);
    assign bresp_o  = bresp_q;
    assign rvalid_o = (state_q == ST_RRESP);
    assign rdata_o  = rdata_q;
    assign rresp_o  = rresp_q;

    a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o));

    a_rdata_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o));

    // the three peripherals never see a write in the same cycle
    a_one_strobe: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0({timer_we_o, pwm_we_o, gpio_we_o}));

endmodule

/* verilog/periph_timer.sv */
// tick runs from reset on; a COUNT above a newly written COMPARE wraps on the next enabled tick
`timescale 1ns/1ps

module periph_timer (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          we_i,
    input  logic [periph_pkg::OFFS_W-1:0] addr_i,
    input  logic [periph_pkg::DATA_W-1:0] wdata_i,
    output logic [periph_pkg::DATA_W-1:0] rdata_o,
    output logic                          tick_o,
    output logic                          irq_o
);
    import periph_pkg::*;

    logic [1:0]       ctrl_q;      // [0] enable, [1] irq enable
    logic [CNT_W-1:0] prescale_q;
    logic [CNT_W-1:0] compare_q;
    logic [CNT_W-1:0] count_q;
    logic [CNT_W-1:0] pre_cnt_q;
    logic             pending_q;
    logic             step;

    // >= so a smaller PRESCALE takes effect at once
    assign tick_o = (pre_cnt_q >= prescale_q);
    assign step   = tick_o && ctrl_q[0];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pre_cnt_q <= '0;
        end else if (tick_o) begin
            pre_cnt_q <= '0;
        end else begin
            pre_cnt_q <= pre_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl_q     <= '0;
            prescale_q <= '0;
            compare_q  <= '0;
            count_q    <= '0;
            pending_q  <= 1'b0;
        end else begin
            if (we_i) begin
                case (addr_i)
                    TMR_CTRL:     ctrl_q     <= wdata_i[1:0];
                    TMR_PRESCALE: prescale_q <= wdata_i[CNT_W-1:0];
                    TMR_COMPARE:  compare_q  <= wdata_i[CNT_W-1:0];
                    TMR_STATUS:   if (wdata_i[0]) pending_q <= 1'b0;
                    default:      ;  // COUNT is read only
                endcase
            end
            if (step) begin
                if (count_q >= compare_q) begin
                    count_q   <= '0;
                    pending_q <= 1'b1;  // a new match beats a clear
                end else begin
                    count_q <= count_q + 1'b1;
                end
            end
        end
    end

    assign irq_o = pending_q & ctrl_q[1];

    always_comb begin
        case (addr_i)
            TMR_CTRL:     rdata_o = DATA_W'(ctrl_q);
            TMR_PRESCALE: rdata_o = DATA_W'(prescale_q);
            TMR_COMPARE:  rdata_o = DATA_W'(compare_q);
            TMR_COUNT:    rdata_o = DATA_W'(count_q);
            TMR_STATUS:   rdata_o = DATA_W'(pending_q);
            default:      rdata_o = '0;
        endcase
    end

    a_irq_needs_pending: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        irq_o |-> pending_q);

endmodule

/* verilog/pwm_bank.sv */
// three channels share one period counter that moves on tick_i; outputs lag the counter by a cycle
`timescale 1ns/1ps

module pwm_bank (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          we_i,
    input  logic [periph_pkg::OFFS_W-1:0] addr_i,
    input  logic [periph_pkg::DATA_W-1:0] wdata_i,
    output logic [periph_pkg::DATA_W-1:0] rdata_o,
    input  logic                          tick_i,
    output logic [periph_pkg::PWM_CH-1:0] pwm_o
);
    import periph_pkg::*;

    logic [CNT_W-1:0]  period_q;
    logic [CNT_W-1:0]  duty_q [PWM_CH];
    logic [PWM_CH-1:0] en_q;
    logic [CNT_W-1:0]  cnt_q;
    logic [PWM_CH-1:0] pwm_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            period_q <= '0;
            en_q     <= '0;
            for (int k = 0; k < PWM_CH; k++) begin
                duty_q[k] <= '0;
            end
        end else if (we_i) begin
            case (addr_i)
                PWM_PERIOD: period_q  <= wdata_i[CNT_W-1:0];
                PWM_DUTY0:  duty_q[0] <= wdata_i[CNT_W-1:0];
                PWM_DUTY1:  duty_q[1] <= wdata_i[CNT_W-1:0];
                PWM_DUTY2:  duty_q[2] <= wdata_i[CNT_W-1:0];
                PWM_ENABLE: en_q      <= wdata_i[PWM_CH-1:0];
                default:    ;
            endcase
        end
    end

    // period counter, wraps after PERIOD
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (tick_i) begin
            if (cnt_q >= period_q) cnt_q <= '0;
            else                   cnt_q <= cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pwm_q <= '0;
        end else begin
            for (int k = 0; k < PWM_CH; k++) begin
                pwm_q[k] <= en_q[k] && (cnt_q < duty_q[k]);
            end
        end
    end

    assign pwm_o = pwm_q;

    always_comb begin
        case (addr_i)
            PWM_PERIOD: rdata_o = DATA_W'(period_q);
            PWM_DUTY0:  rdata_o = DATA_W'(duty_q[0]);
            PWM_DUTY1:  rdata_o = DATA_W'(duty_q[1]);
            PWM_DUTY2:  rdata_o = DATA_W'(duty_q[2]);
            PWM_ENABLE: rdata_o = DATA_W'(en_q);
            default:    rdata_o = '0;
        endcase
    end

    for (genvar k = 0; k < PWM_CH; k++) begin : g_chk
        // a channel disabled now is low on the next cycle
        a_off_low: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            !en_q[k] |=> !pwm_o[k]);
    end

endmodule

/* verilog/gpio_port.sv */
// no pad logic here; gpio_oe_o selects the driver outside and IN lags the pins by two cycles
`timescale 1ns/1ps

module gpio_port (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            we_i,
    input  logic [periph_pkg::OFFS_W-1:0]   addr_i,
    input  logic [periph_pkg::DATA_W-1:0]   wdata_i,
    output logic [periph_pkg::DATA_W-1:0]   rdata_o,
    input  logic [periph_pkg::GPIO_NUM-1:0] gpio_i,
    output logic [periph_pkg::GPIO_NUM-1:0] gpio_o,
    output logic [periph_pkg::GPIO_NUM-1:0] gpio_oe_o
);
    import periph_pkg::*;

    logic [GPIO_NUM-1:0] dir_q;    // 1 = output
    logic [GPIO_NUM-1:0] out_q;
    logic [GPIO_NUM-1:0] sync1_q;
    logic [GPIO_NUM-1:0] sync2_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dir_q <= '0;
            out_q <= '0;
        end else if (we_i) begin
            case (addr_i)
                GPIO_DIR: dir_q <= wdata_i[GPIO_NUM-1:0];
                GPIO_OUT: out_q <= wdata_i[GPIO_NUM-1:0];
                default:  ;  // IN is read only
            endcase
        end
    end

    // pins are asynchronous to clk_i
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync1_q <= '0;
            sync2_q <= '0;
        end else begin
            sync1_q <= gpio_i;
            sync2_q <= sync1_q;
        end
    end

    assign gpio_o    = out_q;
    assign gpio_oe_o = dir_q;

    always_comb begin
        case (addr_i)
            GPIO_DIR: rdata_o = DATA_W'(dir_q);
            GPIO_OUT: rdata_o = DATA_W'(out_q);
            GPIO_IN:  rdata_o = DATA_W'(sync2_q);
            default:  rdata_o = '0;
        endcase
    end

endmodule

/* verilog/periph_soc_top.sv */
// AXI4-Lite slave with timer, pwm and gpio behind it; timer at 0x00, pwm at 0x40, gpio at 0x80
`timescale 1ns/1ps

module periph_soc_top (
    input  logic                            clk_i,
    input  logic                            rst_n_i,

    input  logic [periph_pkg::ADDR_W-1:0]   awaddr_i,
    input  logic                            awvalid_i,
    output logic                            awready_o,
    input  logic [periph_pkg::DATA_W-1:0]   wdata_i,
    input  logic [periph_pkg::DATA_W/8-1:0] wstrb_i,
    input  logic                            wvalid_i,
    output logic                            wready_o,
    output logic [1:0]                      bresp_o,
    output logic                            bvalid_o,
    input  logic                            bready_i,
    input  logic [periph_pkg::ADDR_W-1:0]   araddr_i,
    input  logic                            arvalid_i,
    output logic                            arready_o,
    output logic [periph_pkg::DATA_W-1:0]   rdata_o,
    output logic [1:0]                      rresp_o,
    output logic                            rvalid_o,
    input  logic                            rready_i,

    output logic                            irq_o,
    output logic [periph_pkg::PWM_CH-1:0]   pwm_o,
    input  logic [periph_pkg::GPIO_NUM-1:0] gpio_i,
    output logic [periph_pkg::GPIO_NUM-1:0] gpio_o,
    output logic [periph_pkg::GPIO_NUM-1:0] gpio_oe_o
);
    import periph_pkg::*;

    logic [OFFS_W-1:0] reg_addr;
    logic [DATA_W-1:0] reg_wdata;
    logic              timer_we;
    logic              pwm_we;
    logic              gpio_we;
    logic [DATA_W-1:0] timer_rdata;
    logic [DATA_W-1:0] pwm_rdata;
    logic [DATA_W-1:0] gpio_rdata;
    logic              tick;       // prescaler tick, timer to pwm

    axil_slave_fsm u_axil_slave_fsm (
        .clk_i, .rst_n_i,
        .awaddr_i, .awvalid_i, .awready_o,
        .wdata_i, .wstrb_i, .wvalid_i, .wready_o,
        .bresp_o, .bvalid_o, .bready_i,
        .araddr_i, .arvalid_i, .arready_o,
        .rdata_o, .rresp_o, .rvalid_o, .rready_i,
        .reg_addr_o    (reg_addr),
        .reg_wdata_o   (reg_wdata),
        .timer_we_o    (timer_we),
        .pwm_we_o      (pwm_we),
        .gpio_we_o     (gpio_we),
        .timer_rdata_i (timer_rdata),
        .pwm_rdata_i   (pwm_rdata),
        .gpio_rdata_i  (gpio_rdata)
    );

    periph_timer u_periph_timer (
        .clk_i, .rst_n_i,
        .we_i    (timer_we),
        .addr_i  (reg_addr),
        .wdata_i (reg_wdata),
        .rdata_o (timer_rdata),
        .tick_o  (tick),
        .irq_o
    );

    pwm_bank u_pwm_bank (
        .clk_i, .rst_n_i,
        .we_i    (pwm_we),
        .addr_i  (reg_addr),
        .wdata_i (reg_wdata),
        .rdata_o (pwm_rdata),
        .tick_i  (tick),
        .pwm_o
    );

    gpio_port u_gpio_port (
        .clk_i, .rst_n_i,
        .we_i    (gpio_we),
        .addr_i  (reg_addr),
        .wdata_i (reg_wdata),
        .rdata_o (gpio_rdata),
        .gpio_i, .gpio_o, .gpio_oe_o
    );

endmodule

/* verification/tb_periph_tasks.svh */
// included inside tb_periph_soc_top only; every task starts and ends 1 ns after a rising clk edge
`ifndef TB_PERIPH_TASKS_SVH
`define TB_PERIPH_TASKS_SVH

localparam int NREG = 10;   // read-write registers held in the shadow model

logic [15:0] lfsr_q = 16'd89;
logic [31:0] shadow [NREG];   // all registers reset to zero

// x^16 + x^14 + x^13 + x^11 + 1, one step per returned bit
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
        fb    = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        r     = {r[30:0], fb};
    end
    return r;
endfunction

// timer CTRL PRESCALE COMPARE, pwm PERIOD DUTY0 DUTY1 DUTY2 ENABLE, gpio DIR OUT
function automatic logic [11:0] reg_addr_of(input int idx);
    case (idx)
        0:       return {4'h0, REGION_TIMER, TMR_CTRL};
        1:       return {4'h0, REGION_TIMER, TMR_PRESCALE};
        2:       return {4'h0, REGION_TIMER, TMR_COMPARE};
        3:       return {4'h0, REGION_PWM, PWM_PERIOD};
        4:       return {4'h0, REGION_PWM, PWM_DUTY0};
        5:       return {4'h0, REGION_PWM, PWM_DUTY1};
        6:       return {4'h0, REGION_PWM, PWM_DUTY2};
        7:       return {4'h0, REGION_PWM, PWM_ENABLE};
        8:       return {4'h0, REGION_GPIO, GPIO_DIR};
        default: return {4'h0, REGION_GPIO, GPIO_OUT};
    endcase
endfunction

function automatic logic [31:0] reg_mask_of(input int idx);
    if (idx == 0) return 32'h3;   // enable and irq enable
    if (idx == 7) return 32'h7;   // one bit per channel
    return 32'hFFFF;
endfunction

task automatic bus_write(input logic [11:0] addr, input logic [31:0] data,
                         input logic [3:0] strb, input int stall, output logic [1:0] resp);
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(negedge clk);
    while (!(awready && wready)) @(negedge clk);
    accept_cycle = cycle_cnt;
    @(posedge clk);   // acceptance edge
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    @(negedge clk);
    check_true(bvalid, "bvalid did not rise after the write was accepted");
    resp         = bresp;
    irq_at_bresp = irq;
    repeat (stall) begin
        @(negedge clk);
        check_true(bvalid && bresp == resp, "write response not held under back-pressure");
        check_true(!awready && !wready && !arready, "address accepted while bvalid waits");
    end
    @(posedge clk);
    #1;
    bready = 1'b1;
    @(posedge clk);
    #1;
    bready = 1'b0;
endtask

task automatic bus_read(input logic [11:0] addr, input int stall,
                        output logic [31:0] data, output logic [1:0] resp);
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(posedge clk);   // arvalid held until the response handshake
    @(negedge clk);
    check_true(rvalid, "rvalid did not rise after the read was accepted");
    data = rdata;
    resp = rresp;
    repeat (stall) begin
        @(negedge clk);
        check_true(rvalid && rdata == data && rresp == resp,
                   "read data not held under back-pressure");
        check_true(!awready && !arready, "address accepted while rvalid waits");
    end
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    rready  = 1'b1;
    @(posedge clk);
    #1;
    rready = 1'b0;
endtask

task automatic write_reg(input int idx, input logic [31:0] data);
    logic [1:0] resp;
    bus_write(reg_addr_of(idx), data, 4'hF, 0, resp);
    check_eq(32'(resp), 32'(RESP_OKAY), $sformatf("write response of register %0d", idx));
    shadow[idx] = data & reg_mask_of(idx);
endtask

task automatic verify_reg(input int idx);
    logic [31:0] data;
    logic [1:0]  resp;
    bus_read(reg_addr_of(idx), 0, data, resp);
    check_eq(32'(resp), 32'(RESP_OKAY), $sformatf("read response of register %0d", idx));
    check_eq(data, shadow[idx], $sformatf("readback of register at 0x%03h", reg_addr_of(idx)));
endtask

`endif

/* verification/tb_periph_soc_top.sv */
// self-checking testbench, LFSR seed 89 fixes all stimulus and the run stops at the first mismatch
`timescale 1ns/1ps

module tb_periph_soc_top;
    import periph_pkg::*;

    logic                clk = 1'b0;
    logic                rst_n;
    logic [ADDR_W-1:0]   awaddr;
    logic                awvalid;
    logic                awready;
    logic [DATA_W-1:0]   wdata;
    logic [DATA_W/8-1:0] wstrb;
    logic                wvalid;
    logic                wready;
    logic [1:0]          bresp;
    logic                bvalid;
    logic                bready;
    logic [ADDR_W-1:0]   araddr;
    logic                arvalid;
    logic                arready;
    logic [DATA_W-1:0]   rdata;
    logic [1:0]          rresp;
    logic                rvalid;
    logic                rready;
    logic                irq;
    logic [PWM_CH-1:0]   pwm;
    logic [GPIO_NUM-1:0] gpio_in;
    logic [GPIO_NUM-1:0] gpio_out;
    logic [GPIO_NUM-1:0] gpio_oe;

    int   cycle_cnt = 0;
    int   check_cnt = 0;
    int   accept_cycle;   // cycle count just before the last write was accepted
    logic irq_at_bresp;

    `include "tb_periph_tasks.svh"

    localparam int N_RAND_WR   = 60;
    localparam int N_TMR       = 3;
    localparam int N_PWM       = 4;
    localparam int N_GPIO      = 8;
    localparam int N_BP        = 6;
    localparam int XFER_CYC    = 6;   // one unstalled transaction, rounded up
    localparam int T1_CYC      = (N_RAND_WR + 2 + NREG) * XFER_CYC;
    localparam int T2_CYC      = (12 + NREG) * XFER_CYC;
    localparam int T3_CYC      = N_TMR * (32 * 8 + 2 + 10 * XFER_CYC);
    localparam int T4_CYC      = (1 + 5 * N_PWM) * XFER_CYC + N_PWM * (32 + 4);
    localparam int T5_CYC      = N_GPIO * (3 * XFER_CYC + 6);
    localparam int T6_CYC      = N_BP * (2 * XFER_CYC + 2 * 15);
    localparam int TIMEOUT_CYC = 5 + T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC + T6_CYC + 500;

    periph_soc_top u_periph_soc_top (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .awaddr_i  (awaddr),
        .awvalid_i (awvalid),
        .awready_o (awready),
        .wdata_i   (wdata),
        .wstrb_i   (wstrb),
        .wvalid_i  (wvalid),
        .wready_o  (wready),
        .bresp_o   (bresp),
        .bvalid_o  (bvalid),
        .bready_i  (bready),
        .araddr_i  (araddr),
        .arvalid_i (arvalid),
        .arready_o (arready),
        .rdata_o   (rdata),
        .rresp_o   (rresp),
        .rvalid_o  (rvalid),
        .rready_i  (rready),
        .irq_o     (irq),
        .pwm_o     (pwm),
        .gpio_i    (gpio_in),
        .gpio_o    (gpio_out),
        .gpio_oe_o (gpio_oe)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYC) begin
            fail_run($sformatf("timeout after %0d cycles, the bus stopped responding", cycle_cnt));
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        check_cnt++;
        assert (got === exp) else begin
            fail_run($sformatf("** Error at %0t ns: %s, got 0x%0h, expected 0x%0h",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_true(input logic ok, input string what);
        check_cnt++;
        assert (ok === 1'b1) else begin
            fail_run($sformatf("** Error at %0t ns: %s", $time, what));
        end
    endtask

    initial begin
        logic [1:0]        resp;
        logic [31:0]       data;
        logic [31:0]       exp;
        logic [3:0]        strb;
        logic [PWM_CH-1:0] en;
        int                idx;
        int                bound;
        int                prescale;
        int                compare;
        int                period;
        int                duty [PWM_CH];
        int                high [PWM_CH];

        rst_n   = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        gpio_in = '0;
        for (int i = 0; i < NREG; i++) shadow[i] = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_true(!awready && !wready && !arready && !bvalid && !rvalid && !irq
                   && pwm == '0 && gpio_oe == '0, "outputs not idle during reset");
        @(posedge clk);   // fifth reset cycle
        #1;
        rst_n = 1'b1;

        // random full-word writes, read-only offsets must not change anything
        repeat (N_RAND_WR) begin
            idx = int'(rand_bits(4)) % NREG;
            write_reg(idx, rand_bits(32));
        end
        bus_write({4'h0, REGION_TIMER, TMR_COUNT}, rand_bits(32), 4'hF, 0, resp);
        check_eq(32'(resp), 32'(RESP_OKAY), "COUNT write response");
        bus_write({4'h0, REGION_GPIO, GPIO_IN}, rand_bits(32), 4'hF, 0, resp);
        check_eq(32'(resp), 32'(RESP_OKAY), "GPIO_IN write response");
        for (int i = 0; i < NREG; i++) verify_reg(i);

        // partial strobes and region 3
        repeat (4) begin
            idx  = int'(rand_bits(4)) % NREG;
            strb = 4'(rand_bits(4));
            if (strb == 4'hF) strb = 4'h7;
            bus_write(reg_addr_of(idx), rand_bits(32), strb, 0, resp);
            check_eq(32'(resp), 32'(RESP_SLVERR), "partial strobe write response");
            bus_write({4'h0, REGION_NONE, 6'(rand_bits(6))}, rand_bits(32), 4'hF, 0, resp);
            check_eq(32'(resp), 32'(RESP_SLVERR), "region 3 write response");
            bus_read({4'h0, REGION_NONE, 6'(rand_bits(6))}, 0, data, resp);
            check_eq(32'(resp), 32'(RESP_SLVERR), "region 3 read response");
            check_eq(data, 32'h0, "region 3 read data");
        end
        for (int i = 0; i < NREG; i++) verify_reg(i);

        // timer compare interrupt
        repeat (N_TMR) begin
            prescale = int'(rand_bits(3));
            compare  = int'(rand_bits(5));
            write_reg(0, 32'h0);
            bus_write({4'h0, REGION_TIMER, TMR_STATUS}, 32'h1, 4'hF, 0, resp);
            check_true(!irq, "irq_o high with the timer stopped and pending cleared");
            write_reg(1, prescale);
            write_reg(2, compare);
            write_reg(0, 32'h3);
            bound = (compare + 1) * (prescale + 1) + 2;
            while (!irq && (cycle_cnt - accept_cycle) <= bound) @(negedge clk);
            check_true(irq, $sformatf("irq_o did not rise within %0d cycles", bound));
            @(posedge clk);
            #1;
            bus_read({4'h0, REGION_TIMER, TMR_COUNT}, 0, data, resp);
            check_true(data <= compare, $sformatf("COUNT 0x%0h above COMPARE", data));
            write_reg(0, 32'h2);   // hold the counter, keep irq enable
            bus_write({4'h0, REGION_TIMER, TMR_STATUS}, 32'h1, 4'hF, 0, resp);
            check_true(!irq_at_bresp, "irq_o still high when bvalid was seen");
            bus_read({4'h0, REGION_TIMER, TMR_STATUS}, 0, data, resp);
            check_eq(data, 32'h0, "STATUS after clear");
        end

        // pwm duty count over one full period, tick every cycle
        write_reg(1, 32'h0);
        repeat (N_PWM) begin
            period = int'(rand_bits(5));
            write_reg(3, period);
            for (int k = 0; k < PWM_CH; k++) begin
                duty[k] = int'(rand_bits(6));
                write_reg(4 + k, duty[k]);
            end
            en = 3'(rand_bits(3));
            write_reg(7, en);
            repeat (2) @(posedge clk);
            for (int k = 0; k < PWM_CH; k++) high[k] = 0;
            repeat (period + 1) begin
                @(negedge clk);
                for (int k = 0; k < PWM_CH; k++) high[k] += int'(pwm[k]);
            end
            for (int k = 0; k < PWM_CH; k++) begin
                exp = !en[k] ? 0 : (duty[k] < period + 1) ? duty[k] : period + 1;
                check_eq(high[k], exp, $sformatf("pwm_o[%0d] high cycles", k));
            end
            @(posedge clk);
            #1;
        end

        // gpio outputs and synchronized input
        repeat (N_GPIO) begin
            write_reg(8, rand_bits(16));
            write_reg(9, rand_bits(16));
            @(negedge clk);
            check_eq(32'(gpio_oe), shadow[8], "gpio_oe_o");
            check_eq(32'(gpio_out), shadow[9], "gpio_o");
            @(posedge clk);
            #1;
            exp     = rand_bits(16);
            gpio_in = exp[GPIO_NUM-1:0];
            repeat (3) @(posedge clk);
            #1;
            bus_read({4'h0, REGION_GPIO, GPIO_IN}, 0, data, resp);
            check_eq(data, exp, "GPIO_IN");
        end

        // back-pressure, a read waits behind a stalled write response
        repeat (N_BP) begin
            idx     = int'(rand_bits(4)) % NREG;
            data    = rand_bits(32);
            araddr  = reg_addr_of(idx);
            arvalid = 1'b1;
            bus_write(reg_addr_of(idx), data, 4'hF, int'(rand_bits(4)), resp);
            check_eq(32'(resp), 32'(RESP_OKAY), "write response under back-pressure");
            shadow[idx] = data & reg_mask_of(idx);
            bus_read(reg_addr_of(idx), int'(rand_bits(4)), data, resp);
            check_eq(data, shadow[idx], "readback under back-pressure");
        end

        if (check_cnt > 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            fail_run("no checks were executed");
        end
    end

endmodule

/* project.f */
+incdir+verification
verilog/periph_pkg.sv
verilog/axil_slave_fsm.sv
verilog/periph_timer.sv
verilog/pwm_bank.sv
verilog/gpio_port.sv
verilog/periph_soc_top.sv
verification/tb_periph_soc_top.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the testbench with Verilator, exit status follows the simulation

cd "$(dirname "$0")" || exit 1

TOP=tb_periph_soc_top
BUILD_DIR=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" --Mdir "$BUILD_DIR" -o "V$TOP" \
    -f project.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

"./$BUILD_DIR/V$TOP"
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

echo "simulation finished with status 0"
exit 0
